//--- dv/spi_vectors.txt
# name, byte count, seven MOSI bytes, seven expected MISO bytes, expected err_out
# Slots past the byte count are 00, the first MISO byte is the status byte
wr_single      4 0a 00 05 a5 00 00 00  00 00 00 00 00 00 00  0
rd_single      4 02 00 05 00 00 00 00  02 00 00 a5 00 00 00  0

# Continuous write from address 10, then read back in order
wr_cont4       7 0e 00 0a 11 22 33 44  04 00 00 00 00 00 00  0
rd_cont4       7 06 00 0a 00 00 00 00  06 00 00 11 22 33 44  0

# One address byte and two address bytes hit the same register
rd_addr1       3 01 0b 00 00 00 00 00  08 00 22 00 00 00 00  0
rd_addr2_same  4 02 00 0b 00 00 00 00  0a 00 00 22 00 00 00  0

# Error frames, status bit 0 carries the flag into the next frame
rd_range       4 02 00 40 00 00 00 00  0c 00 00 00 00 00 00  1
bad_alen       2 03 00 00 00 00 00 00  0f 00 00 00 00 00 00  1
wr_extra       5 0a 00 06 5a 77 00 00  11 00 00 00 00 00 00  1
rd_after_err   4 02 00 06 00 00 00 00  13 00 00 5a 00 00 00  0
rd_err_clear   4 02 00 05 00 00 00 00  14 00 00 a5 00 00 00  0

//--- sim.f
hw/spi_pkg.sv
hw/byte_if.sv
hw/reg_if.sv
hw/spi_pin_sync.sv
hw/spi_shifter.sv
hw/spi_frame_ctrl.sv
hw/spi_reg_bank.sv
hw/spi_slave_top.sv
dv/tb_spi_slave.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_spi_slave
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= TEST FAIL
PASS_MSG   ?= TEST PASS
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Failure found in $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/tb_spi_slave.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spi_slave import spi_pkg::*; ();

    logic clk;
    logic rst;
    logic sclk;
    logic cs_n;
    logic mosi;
    logic miso;
    logic busy;
    logic err_out;
    logic frame_done;

    // One entry per frame with seven byte slots each
    string     vec_name[$];
    int        vec_len[$];
    spi_byte_t vec_tx[$];
    spi_byte_t vec_exp[$];
    logic      vec_err[$];

    string       cur_name = "reset";
    int          half;                  // SCLK half period in clk cycles
    int          frames_done;           // Completed frames seen by the master
    logic        last_err;              // Expected error of the previous frame
    int unsigned cycle_cnt = 0;
    int unsigned cycle_limit = 0;       // Zero until the vectors are loaded

    spi_slave_top u_spi_slave_top (
        .clk        (clk),
        .rst        (rst),
        .sclk       (sclk),
        .cs_n       (cs_n),
        .mosi       (mosi),
        .miso       (miso),
        .busy       (busy),
        .err_out    (err_out),
        .frame_done (frame_done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_on_failure(input string msg);
        $display("%0s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            stop_on_failure($sformatf("Timeout in %0s, no frame end after %0d cycles",
                                      cur_name, cycle_cnt));
        end
    end

    task automatic check_byte(input string what, input spi_byte_t exp, input spi_byte_t act);
        if (act !== exp) begin
            stop_on_failure($sformatf("ERROR %0s %0s: expected %02h actual %02h",
                                      cur_name, what, exp, act));
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_failure($sformatf("ERROR %0s %0s: expected %0b actual %0b",
                                      cur_name, what, exp, act));
        end
    endtask

    // Strip the zero padding that %s leaves in a packed vector
    function automatic string trim_name(input logic [8*16-1:0] raw);
        string s;
        s = "";
        for (int i = 15; i >= 0; i--) begin
            if (raw[i*8 +: 8] != 8'h00) begin
                s = {s, $sformatf("%c", raw[i*8 +: 8])};
            end
        end
        return s;
    endfunction

    task automatic load_vectors();
        int              fd;
        int              got;
        int              len;
        string           line;
        logic [8*16-1:0] name;
        logic            err;
        spi_byte_t       tx[7];
        spi_byte_t       ex[7];
        fd = $fopen("dv/spi_vectors.txt", "r");
        if (fd == 0) begin
            stop_on_failure("Cannot open the vector file dv/spi_vectors.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 3 || line.getc(0) == "#") begin
                continue;  // Blank or comment line
            end
            name = '0;
            got  = $sscanf(line, "%s %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                           name, len,
                           tx[0], tx[1], tx[2], tx[3], tx[4], tx[5], tx[6],
                           ex[0], ex[1], ex[2], ex[3], ex[4], ex[5], ex[6],
                           err);
            if (got != 17 || len < 1 || len > 7) begin
                stop_on_failure({"Malformed line in the vector file: ", line});
            end
            vec_name.push_back(trim_name(name));
            vec_len.push_back(len);
            for (int j = 0; j < 7; j++) begin
                vec_tx.push_back(tx[j]);
                vec_exp.push_back(ex[j]);
            end
            vec_err.push_back(err);
        end
        $fclose(fd);
        if (vec_name.size() == 0) begin
            stop_on_failure("The vector file holds no frames");
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // Mode 0 master that changes MOSI with SCLK low and captures MISO at the rise
    task automatic shift_byte(input spi_byte_t tx, output spi_byte_t rx);
        for (int b = 7; b >= 0; b--) begin
            mosi = tx[b];
            wait_cycles(half);
            sclk  = 1'b1;
            rx[b] = miso;
            wait_cycles(half);
            sclk = 1'b0;
        end
    endtask

    task automatic run_frame(input int idx);
        spi_byte_t got;
        spi_byte_t status_model;
        cur_name     = vec_name[idx];
        half         = $urandom_range(12, 8);
        status_model = {frames_done[6:0], last_err};  // Count in 7:1 and error in 0
        cs_n = 1'b0;
        wait_cycles(half);
        check_flag("busy in frame", 1'b1, busy);
        for (int k = 0; k < vec_len[idx]; k++) begin
            shift_byte(vec_tx[idx*7 + k], got);
            if (k == 0) begin
                check_byte("status byte", status_model, got);
            end
            check_byte($sformatf("miso byte %0d", k), vec_exp[idx*7 + k], got);
        end
        wait_cycles(half);
        cs_n = 1'b1;
        mosi = 1'b0;
        while (!frame_done) begin
            @(negedge clk);
        end
        check_flag("err_out", vec_err[idx], err_out);
        check_flag("busy at frame_done", 1'b0, busy);
        frames_done = frames_done + 1;
        last_err    = vec_err[idx];
        wait_cycles(half);  // cs_n high gap between frames
    endtask

    initial begin
        rst         = 1'b0;
        sclk        = 1'b0;
        cs_n        = 1'b1;
        mosi        = 1'b0;
        half        = 8;
        frames_done = 0;
        last_err    = 1'b0;
        void'($urandom(15));
        load_vectors();

        // Worst case bit time plus frame overhead and reset
        cycle_limit = 25;
        foreach (vec_len[i]) begin
            cycle_limit += vec_len[i] * 8 * 2 * 12 + 50;
        end

        repeat (5) @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        check_flag("busy after reset", 1'b0, busy);
        check_flag("err_out after reset", 1'b0, err_out);
        check_flag("frame_done after reset", 1'b0, frame_done);
        check_flag("miso after reset", 1'b0, miso);

        for (int i = 0; i < vec_name.size(); i++) begin
            run_frame(i);
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/spi_slave_top.sv
`timescale 1ns/1ps
`default_nettype none

module spi_slave_top (
    input  logic clk,
    input  logic rst,
    input  logic sclk,
    input  logic cs_n,
    input  logic mosi,
    output logic miso,
    output logic busy,
    output logic err_out,
    output logic frame_done
);

    logic sclk_rise;
    logic sclk_fall;
    logic cs_active;
    logic mosi_s;

    byte_if u_byte_if ();  // Shifter to controller
    reg_if  u_reg_if ();   // Controller to bank

    spi_pin_sync u_spi_pin_sync (
        .clk       (clk),
        .rst       (rst),
        .sclk      (sclk),
        .cs_n      (cs_n),
        .mosi      (mosi),
        .sclk_rise (sclk_rise),
        .sclk_fall (sclk_fall),
        .cs_active (cs_active),
        .mosi_s    (mosi_s)
    );

    spi_shifter u_spi_shifter (
        .clk       (clk),
        .rst       (rst),
        .sclk_rise (sclk_rise),
        .sclk_fall (sclk_fall),
        .cs_active (cs_active),
        .mosi_s    (mosi_s),
        .bus       (u_byte_if),
        .miso      (miso)
    );

    spi_frame_ctrl u_spi_frame_ctrl (
        .clk        (clk),
        .rst        (rst),
        .cs_active  (cs_active),
        .bus        (u_byte_if),
        .regs       (u_reg_if),
        .busy       (busy),
        .err_out    (err_out),
        .frame_done (frame_done)
    );

    spi_reg_bank u_spi_reg_bank (
        .clk  (clk),
        .rst  (rst),
        .regs (u_reg_if)
    );

endmodule

`default_nettype wire

//--- hw/spi_reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

module spi_reg_bank import spi_pkg::*; (
    input  logic clk,
    input  logic rst,
    reg_if.slave regs
);

    spi_byte_t         mem [REG_DEPTH];
    logic [REG_AW-1:0] idx;
    logic              in_range;

    assign idx      = regs.addr[REG_AW-1:0];
    assign in_range = (regs.addr < spi_addr_t'(REG_DEPTH));

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < REG_DEPTH; i++) begin
                mem[i] <= '0;
            end
            regs.ack       <= 1'b0;
            regs.rdata     <= '0;
            regs.range_err <= 1'b0;
        end else if (regs.req && !regs.ack) begin
            // New request answered on the next cycle
            regs.ack       <= 1'b1;
            regs.range_err <= !in_range;
            regs.rdata     <= '0;  // Out of range reads return zero
            if (in_range) begin
                if (regs.we) begin
                    mem[idx] <= regs.wdata;
                end else begin
                    regs.rdata <= mem[idx];
                end
            end
        end else if (!regs.req) begin
            regs.ack <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hw/spi_frame_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module spi_frame_ctrl import spi_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  cs_active,
    byte_if.ctrl  bus,
    reg_if.master regs,
    output logic  busy,
    output logic  err_out,
    output logic  frame_done
);

    frame_state_t state;
    spi_addr_t    addr;
    alen_t        addr_left;  // Address bytes still to come
    alen_t        alen;
    frame_cnt_t   frame_cnt;
    spi_byte_t    status;
    logic         cont;
    logic         wr;
    logic         data_seen;  // At least one data byte in this frame
    logic         frame_err;
    logic         rd_err;     // Range error on the prefetched read byte

    always_comb begin
        status                 = {frame_cnt, 1'b0};
        status[STATUS_ERR_BIT] = err_out;
    end

    assign alen      = bus.rx_byte[CMD_ALEN_LSB +: 2];
    assign busy      = (state != st_idle);
    assign regs.addr = addr;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state       <= st_idle;
            regs.req    <= 1'b0;
            regs.we     <= 1'b0;
            bus.tx_load <= 1'b0;
            frame_done  <= 1'b0;
            err_out     <= 1'b0;
            frame_cnt   <= '0;
            frame_err   <= 1'b0;
            rd_err      <= 1'b0;
            cont        <= 1'b0;
            wr          <= 1'b0;
            data_seen   <= 1'b0;
            addr_left   <= '0;
        end else begin
            bus.tx_load <= 1'b0;
            frame_done  <= 1'b0;

            // Queue zeros behind each byte that went out
            if (state != st_idle && bus.tx_taken) begin
                bus.tx_byte <= '0;
                bus.tx_load <= 1'b1;
            end

            // A running handshake is always finished before the frame closes
            if (state != st_idle && state != st_wait_ack && !cs_active) begin
                state      <= st_idle;
                frame_done <= 1'b1;
                err_out    <= frame_err;
                frame_cnt  <= frame_cnt + 1'b1;
            end else begin
                case (state)
                    st_idle: if (cs_active) begin
                        state       <= st_cmd;
                        bus.tx_byte <= status;
                        bus.tx_load <= 1'b1;
                        addr        <= '0;
                        data_seen   <= 1'b0;
                        frame_err   <= 1'b0;
                        rd_err      <= 1'b0;
                    end
                    st_cmd: if (bus.rx_valid) begin
                        cont      <= bus.rx_byte[CMD_CONT_BIT];
                        wr        <= bus.rx_byte[CMD_WRITE_BIT];
                        addr_left <= alen;
                        if (alen == 2'd3) begin
                            frame_err <= 1'b1;  // Illegal address length
                            state     <= st_drop;
                        end else if (alen != 2'd0) begin
                            state <= st_addr;
                        end else if (!bus.rx_byte[CMD_WRITE_BIT]) begin
                            regs.req <= 1'b1;   // Prefetch from address zero
                            regs.we  <= 1'b0;
                            state    <= st_wait_ack;
                        end else begin
                            state <= st_data;
                        end
                    end
                    st_addr: if (bus.rx_valid) begin
                        addr      <= {addr[7:0], bus.rx_byte};  // High byte first
                        addr_left <= addr_left - 1'b1;
                        if (addr_left == 2'd1) begin
                            if (wr) begin
                                state <= st_data;
                            end else begin
                                regs.req <= 1'b1;
                                regs.we  <= 1'b0;
                                state    <= st_wait_ack;
                            end
                        end
                    end
                    st_data: if (bus.rx_valid) begin
                        data_seen <= 1'b1;
                        rd_err    <= 1'b0;
                        if (rd_err) begin
                            frame_err <= 1'b1;
                        end
                        if (data_seen && !cont) begin
                            frame_err <= 1'b1;  // Single mode takes one byte only
                            state     <= st_drop;
                        end else if (wr) begin
                            regs.req   <= 1'b1;
                            regs.we    <= 1'b1;
                            regs.wdata <= bus.rx_byte;
                            state      <= st_wait_ack;
                        end else if (cont) begin
                            addr     <= addr + 1'b1;  // Fetch the next byte ahead
                            regs.req <= 1'b1;
                            regs.we  <= 1'b0;
                            state    <= st_wait_ack;
                        end
                    end
                    st_wait_ack: begin
                        if (regs.req && regs.ack) begin
                            regs.req <= 1'b0;
                            if (regs.we) begin
                                if (regs.range_err) begin
                                    frame_err <= 1'b1;
                                end
                                if (cont) begin
                                    addr <= addr + 1'b1;
                                end
                            end else begin
                                bus.tx_byte <= regs.rdata;
                                bus.tx_load <= 1'b1;
                                rd_err      <= regs.range_err;
                            end
                        end else if (!regs.req && !regs.ack) begin
                            state <= st_data;
                        end
                    end
                    default: begin
                        // st_drop ignores bytes until cs_n rises
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/spi_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module spi_shifter import spi_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    sclk_rise,
    input  logic    sclk_fall,
    input  logic    cs_active,
    input  logic    mosi_s,
    byte_if.shifter bus,
    output logic    miso
);

    spi_byte_t rx_shift;
    spi_byte_t tx_shift;
    spi_byte_t tx_hold;      // Next byte waiting for the byte boundary
    bit_cnt_t  bit_cnt;
    logic      frame_start;  // No falling edge seen yet in this frame

    assign bus.rx_byte = rx_shift;
    assign miso        = tx_shift[7];  // MSB first

    always_ff @(posedge clk) begin
        if (!rst) begin
            bit_cnt      <= '0;
            bus.rx_valid <= 1'b0;
        end else begin
            bus.rx_valid <= 1'b0;
            if (!cs_active) begin
                bit_cnt <= '0;  // Byte aligned at every frame start
            end else if (sclk_rise) begin
                bit_cnt      <= bit_cnt + 1'b1;
                bus.rx_valid <= (bit_cnt == 3'd7);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cs_active && sclk_rise) begin
            rx_shift <= {rx_shift[6:0], mosi_s};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            tx_shift     <= '0;
            tx_hold      <= '0;
            frame_start  <= 1'b1;
            bus.tx_taken <= 1'b0;
        end else begin
            bus.tx_taken <= 1'b0;
            if (!cs_active) begin
                tx_shift    <= '0;  // MISO rests low between frames
                frame_start <= 1'b1;
            end else if (sclk_fall) begin
                frame_start <= 1'b0;
                if (bit_cnt == '0) begin  // Fall after the eighth rise
                    tx_shift     <= tx_hold;
                    bus.tx_taken <= 1'b1;
                end else begin
                    tx_shift <= {tx_shift[6:0], 1'b0};
                end
            end

            // First byte of a frame must be on MISO before the first rise
            if (bus.tx_load) begin
                if (frame_start) begin
                    tx_shift <= bus.tx_byte;
                    tx_hold  <= '0;
                end else begin
                    tx_hold <= bus.tx_byte;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/spi_pin_sync.sv
`timescale 1ns/1ps
`default_nettype none

module spi_pin_sync (
    input  logic clk,
    input  logic rst,
    input  logic sclk,
    input  logic cs_n,
    input  logic mosi,
    output logic sclk_rise,
    output logic sclk_fall,
    output logic cs_active,
    output logic mosi_s
);

    logic sclk_meta, sclk_sync, sclk_last;
    logic cs_meta, cs_sync;
    logic mosi_meta, mosi_sync;

    always_ff @(posedge clk) begin
        if (!rst) begin
            sclk_meta <= 1'b0;
            sclk_sync <= 1'b0;
            sclk_last <= 1'b0;
            cs_meta   <= 1'b1;  // Pins idle with no frame open
            cs_sync   <= 1'b1;
            mosi_meta <= 1'b0;
            mosi_sync <= 1'b0;
            sclk_rise <= 1'b0;
            sclk_fall <= 1'b0;
            cs_active <= 1'b0;
            mosi_s    <= 1'b0;
        end else begin
            sclk_meta <= sclk;
            sclk_sync <= sclk_meta;
            cs_meta   <= cs_n;
            cs_sync   <= cs_meta;
            mosi_meta <= mosi;
            mosi_sync <= mosi_meta;

            // Third stage keeps cs and mosi aligned with the edge pulses
            sclk_last <= sclk_sync;
            sclk_rise <= sclk_sync & ~sclk_last;
            sclk_fall <= ~sclk_sync & sclk_last;
            cs_active <= ~cs_sync;
            mosi_s    <= mosi_sync;
        end
    end

endmodule

`default_nettype wire

//--- hw/reg_if.sv
`timescale 1ns/1ps
`default_nettype none

interface reg_if import spi_pkg::*; ();

    logic      req;
    logic      we;
    spi_addr_t addr;
    spi_byte_t wdata;
    logic      ack;
    spi_byte_t rdata;      // Valid while ack is high
    logic      range_err;  // Address at or past the end of the bank

    modport master (
        output req, we, addr, wdata,
        input  ack, rdata, range_err
    );

    modport slave (
        input  req, we, addr, wdata,
        output ack, rdata, range_err
    );

endinterface

`default_nettype wire

//--- hw/byte_if.sv
`timescale 1ns/1ps
`default_nettype none

interface byte_if import spi_pkg::*; ();

    spi_byte_t rx_byte;   // Last complete MOSI byte
    logic      rx_valid;  // Pulse after bit 7 is sampled
    logic      tx_taken;  // Queued byte moved into the MISO shifter
    spi_byte_t tx_byte;
    logic      tx_load;

    modport shifter (
        output rx_byte, rx_valid, tx_taken,
        input  tx_byte, tx_load
    );

    modport ctrl (
        input  rx_byte, rx_valid, tx_taken,
        output tx_byte, tx_load
    );

endinterface

`default_nettype wire

//--- hw/spi_pkg.sv
`default_nettype none

package spi_pkg;

    // Frame data widths
    typedef logic [7:0]  spi_byte_t;
    typedef logic [15:0] spi_addr_t;
    typedef logic [2:0]  bit_cnt_t;    // Bit position inside a byte
    typedef logic [1:0]  alen_t;       // Address byte count from the command
    typedef logic [6:0]  frame_cnt_t;  // Completed frames, wraps at 128

    // Frame controller states
    typedef enum logic [2:0] {
        st_idle,
        st_cmd,
        st_addr,
        st_data,
        st_wait_ack,
        st_drop
    } frame_state_t;

    // Register bank size
    localparam int REG_DEPTH = 64;
    localparam int REG_AW    = $clog2(REG_DEPTH);

    // Command byte layout
    localparam int CMD_WRITE_BIT = 3;
    localparam int CMD_CONT_BIT  = 2;
    localparam int CMD_ALEN_LSB  = 0;  // Two bits wide

    // Status byte layout with the frame count in bits 7:1
    localparam int STATUS_ERR_BIT = 0;

endpackage

`default_nettype wire
